//--- list.f
+incdir+logic
logic/vx_pkg.sv
logic/vx_front_end.sv
logic/vx_scheduler.sv
logic/vx_back_end.sv
logic/vx_mem_controller.sv
logic/vx_core.sv
verif/vx_core_assertions.sv
verif/vx_core_tb.sv

//--- logic/vx_back_end.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_back_end
	import vx_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue,
	input  instr_t               instr,
	input  logic                 d_req_ready,
	input  logic                 d_rsp_valid,
	input  logic [`XLEN-1:0]     d_rsp_data,
	output logic                 d_req_valid,
	output logic                 d_req_write,
	output logic [`XLEN-1:0]     d_req_addr,
	output logic [`XLEN-1:0]     d_req_data,
	output logic                 wb_valid,
	output logic [`REG_BITS-1:0] wb_rd,
	output logic                 mem_delay
);

	logic [`XLEN-1:0]     regs [`NUM_REGS];
	logic [`XLEN-1:0]     rs1_val;
	logic [`XLEN-1:0]     rs2_val;
	logic [`XLEN-1:0]     rd_val;
	logic [`XLEN-1:0]     imm_ext;
	logic [`XLEN-1:0]     wb_data;
	logic                 is_alu;
	logic                 is_mem;
	logic                 load_done;
	logic                 alu_valid;
	logic [`XLEN-1:0]     alu_result;
	logic                 req_valid;
	logic                 mem_busy;
	logic                 mem_write;
	logic [`REG_BITS-1:0] dest_rd;
	logic [`XLEN-1:0]     mem_addr;
	logic [`XLEN-1:0]     mem_data;

	// r0 reads zero
	assign rs1_val = (instr.r.rs1 == '0) ? '0 : regs[instr.r.rs1];
	assign rs2_val = (instr.r.rs2 == '0) ? '0 : regs[instr.r.rs2];
	assign rd_val  = (instr.i.rd == '0) ? '0 : regs[instr.i.rd];
	assign imm_ext = {{(`XLEN-16){instr.i.imm[15]}}, instr.i.imm};

	assign is_alu = (instr.r.opcode == `OP_ADD) || (instr.i.opcode == `OP_ADDI);
	assign is_mem = (instr.i.opcode == `OP_LW) || (instr.i.opcode == `OP_SW);

	// One instruction in flight, so one destination register
	assign load_done = d_rsp_valid && mem_busy && !mem_write;
	assign wb_valid  = alu_valid || load_done;
	assign wb_rd     = dest_rd;
	assign wb_data   = alu_valid ? alu_result : d_rsp_data;

	assign d_req_valid = req_valid;
	assign d_req_write = mem_write;
	assign d_req_addr  = mem_addr;
	assign d_req_data  = mem_data;
	assign mem_delay   = mem_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			alu_valid <= 1'b0;
			req_valid <= 1'b0;
			mem_busy  <= 1'b0;
		end else begin
			alu_valid <= issue && is_alu;
			if (issue && is_mem) begin
				req_valid <= 1'b1;
				mem_busy  <= 1'b1;
			end else begin
				if (req_valid && d_req_ready) begin
					req_valid <= 1'b0;
					// Store is done once accepted
					if (mem_write) begin
						mem_busy <= 1'b0;
					end
				end
				if (load_done) begin
					mem_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			dest_rd    <= instr.i.rd;
			alu_result <= rs1_val + ((instr.r.opcode == `OP_ADD) ? rs2_val : imm_ext);
			mem_write  <= (instr.i.opcode == `OP_SW);
			mem_addr   <= rs1_val + imm_ext;
			mem_data   <= rd_val;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

//--- logic/vx_core.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_core
	import vx_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	output logic             io_valid,
	output logic [`XLEN-1:0] io_data,
	output logic             dram_req_read,
	output logic             dram_req_write,
	output logic [`XLEN-1:0] dram_req_addr,
	output logic [`XLEN-1:0] dram_req_data,
	input  logic             dram_req_ready,
	input  logic             dram_rsp_valid,
	input  logic [`XLEN-1:0] dram_rsp_data,
	output logic             dram_rsp_ready,
	output logic             out_ebreak
);

	logic                 if_req_valid;
	logic [`XLEN-1:0]     if_req_addr;
	logic                 if_req_ready;
	logic                 if_rsp_valid;
	logic [`XLEN-1:0]     if_rsp_data;
	logic                 d_req_valid;
	logic                 d_req_write;
	logic [`XLEN-1:0]     d_req_addr;
	logic [`XLEN-1:0]     d_req_data;
	logic                 d_req_ready;
	logic                 mc_d_req_valid;
	logic                 mc_d_req_ready;
	logic                 d_rsp_valid;
	logic [`XLEN-1:0]     d_rsp_data;
	logic                 instr_valid;
	instr_t               instr;
	logic                 schedule_delay;
	logic                 is_empty;
	logic                 issue;
	logic                 mem_delay;
	logic                 wb_valid;
	logic [`REG_BITS-1:0] wb_rd;

	assign issue = instr_valid && !schedule_delay;

	// IO stores are taken here and never reach DRAM
	assign io_valid       = d_req_valid && d_req_write && (d_req_addr == `IO_BUS_ADDR);
	assign io_data        = d_req_data;
	assign mc_d_req_valid = d_req_valid && !io_valid;
	assign d_req_ready    = io_valid || mc_d_req_ready;

	vx_front_end front_end (
		.clk            (clk),
		.reset          (reset),
		.schedule_delay (schedule_delay),
		.is_empty       (is_empty),
		.if_req_ready   (if_req_ready),
		.if_rsp_valid   (if_rsp_valid),
		.if_rsp_data    (if_rsp_data),
		.if_req_valid   (if_req_valid),
		.if_req_addr    (if_req_addr),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.fetch_ebreak   (out_ebreak)
	);

	vx_scheduler scheduler (
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.mem_delay      (mem_delay),
		.wb_valid       (wb_valid),
		.wb_rd          (wb_rd),
		.schedule_delay (schedule_delay),
		.is_empty       (is_empty)
	);

	vx_back_end back_end (
		.clk         (clk),
		.reset       (reset),
		.issue       (issue),
		.instr       (instr),
		.d_req_ready (d_req_ready),
		.d_rsp_valid (d_rsp_valid),
		.d_rsp_data  (d_rsp_data),
		.d_req_valid (d_req_valid),
		.d_req_write (d_req_write),
		.d_req_addr  (d_req_addr),
		.d_req_data  (d_req_data),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.mem_delay   (mem_delay)
	);

	vx_mem_controller mem_controller (
		.clk            (clk),
		.reset          (reset),
		.if_req_valid   (if_req_valid),
		.if_req_addr    (if_req_addr),
		.if_req_ready   (if_req_ready),
		.if_rsp_valid   (if_rsp_valid),
		.if_rsp_data    (if_rsp_data),
		.d_req_valid    (mc_d_req_valid),
		.d_req_write    (d_req_write),
		.d_req_addr     (d_req_addr),
		.d_req_data     (d_req_data),
		.d_req_ready    (mc_d_req_ready),
		.d_rsp_valid    (d_rsp_valid),
		.d_rsp_data     (d_rsp_data),
		.dram_req_read  (dram_req_read),
		.dram_req_write (dram_req_write),
		.dram_req_addr  (dram_req_addr),
		.dram_req_data  (dram_req_data),
		.dram_req_ready (dram_req_ready),
		.dram_rsp_valid (dram_rsp_valid),
		.dram_rsp_data  (dram_rsp_data),
		.dram_rsp_ready (dram_rsp_ready)
	);

endmodule

//--- logic/vx_defines.svh
`ifndef VX_DEFINES_SVH
`define VX_DEFINES_SVH

// Datapath and register file
`define XLEN        32
`define NUM_REGS    16
`define REG_BITS    4
`define OP_BITS     4

// Opcodes
`define OP_ADD      4'h1
`define OP_ADDI     4'h2
`define OP_LW       4'h3
`define OP_SW       4'h4
`define OP_EBREAK   4'hf

// Stores here go to io_data, not to DRAM
`define IO_BUS_ADDR 32'hffff_fff0

`define RESET_PC    32'h0000_0000

`endif

//--- logic/vx_front_end.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_front_end
	import vx_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             schedule_delay,
	input  logic             is_empty,
	input  logic             if_req_ready,
	input  logic             if_rsp_valid,
	input  logic [`XLEN-1:0] if_rsp_data,
	output logic             if_req_valid,
	output logic [`XLEN-1:0] if_req_addr,
	output logic             instr_valid,
	output instr_t           instr,
	output logic             fetch_ebreak
);

	logic             req_valid;
	logic             rsp_wait;
	logic             halted;
	logic [`XLEN-1:0] pc;
	logic             issue;
	logic             fetch_next;
	instr_t           rsp_instr;

	assign issue     = instr_valid && !schedule_delay;
	assign rsp_instr = if_rsp_data;

	// Next word only once the held one is gone
	assign fetch_next = !req_valid && !rsp_wait && !halted && (!instr_valid || issue);

	assign if_req_valid = req_valid;
	assign if_req_addr  = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			req_valid    <= 1'b0;
			rsp_wait     <= 1'b0;
			halted       <= 1'b0;
			instr_valid  <= 1'b0;
			fetch_ebreak <= 1'b0;
			pc           <= `RESET_PC;
		end else begin
			if (fetch_next) begin
				req_valid <= 1'b1;
			end else if (req_valid && if_req_ready) begin
				req_valid <= 1'b0;
			end

			if (req_valid && if_req_ready) begin
				rsp_wait <= 1'b1;
			end else if (if_rsp_valid) begin
				rsp_wait <= 1'b0;
			end

			if (if_rsp_valid) begin
				pc <= pc + 32'd4;
				// EBREAK stops fetch and is never handed on
				if (rsp_instr.r.opcode == `OP_EBREAK) begin
					halted <= 1'b1;
				end else begin
					instr_valid <= 1'b1;
				end
			end else if (issue) begin
				instr_valid <= 1'b0;
			end

			if (halted && is_empty) begin
				fetch_ebreak <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (if_rsp_valid) begin
			instr <= rsp_instr;
		end
	end

endmodule

//--- logic/vx_mem_controller.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_mem_controller
	import vx_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             if_req_valid,
	input  logic [`XLEN-1:0] if_req_addr,
	output logic             if_req_ready,
	output logic             if_rsp_valid,
	output logic [`XLEN-1:0] if_rsp_data,
	input  logic             d_req_valid,
	input  logic             d_req_write,
	input  logic [`XLEN-1:0] d_req_addr,
	input  logic [`XLEN-1:0] d_req_data,
	output logic             d_req_ready,
	output logic             d_rsp_valid,
	output logic [`XLEN-1:0] d_rsp_data,
	output logic             dram_req_read,
	output logic             dram_req_write,
	output logic [`XLEN-1:0] dram_req_addr,
	output logic [`XLEN-1:0] dram_req_data,
	input  logic             dram_req_ready,
	input  logic             dram_rsp_valid,
	input  logic [`XLEN-1:0] dram_rsp_data,
	output logic             dram_rsp_ready
);

	logic       read_busy;
	mem_owner_e rsp_owner;
	logic       hold;
	mem_owner_e hold_owner;
	logic       sel_data;
	logic       active;

	// A stalled grant keeps its side until it transfers
	assign sel_data = hold ? (hold_owner == DATA) : d_req_valid;
	assign active   = !read_busy && (sel_data ? d_req_valid : if_req_valid);

	assign dram_req_read  = active && (!sel_data || !d_req_write);
	assign dram_req_write = active && sel_data && d_req_write;
	assign dram_req_addr  = sel_data ? d_req_addr : if_req_addr;
	assign dram_req_data  = d_req_data;

	assign d_req_ready  = active && sel_data && dram_req_ready;
	assign if_req_ready = active && !sel_data && dram_req_ready;

	// Never refuse a response for our one outstanding read
	assign dram_rsp_ready = read_busy;
	assign if_rsp_valid   = dram_rsp_valid && read_busy && (rsp_owner == IFETCH);
	assign d_rsp_valid    = dram_rsp_valid && read_busy && (rsp_owner == DATA);
	assign if_rsp_data    = dram_rsp_data;
	assign d_rsp_data     = dram_rsp_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			read_busy  <= 1'b0;
			rsp_owner  <= IFETCH;
			hold       <= 1'b0;
			hold_owner <= IFETCH;
		end else begin
			if (active && !dram_req_ready) begin
				hold       <= 1'b1;
				hold_owner <= sel_data ? DATA : IFETCH;
			end else if (active) begin
				hold <= 1'b0;
			end

			if (dram_req_read && dram_req_ready) begin
				read_busy <= 1'b1;
				rsp_owner <= sel_data ? DATA : IFETCH;
			end else if (dram_rsp_valid && dram_rsp_ready) begin
				read_busy <= 1'b0;
			end
		end
	end

endmodule

//--- logic/vx_pkg.sv
`include "vx_defines.svh"

package vx_pkg;

	// Register-register format
	typedef struct packed {
		logic [`OP_BITS-1:0]  opcode;
		logic [`REG_BITS-1:0] rd;
		logic [`REG_BITS-1:0] rs1;
		logic [`REG_BITS-1:0] rs2;
		logic [15:0]          unused;
	} instr_r_t;

	// Immediate format, also used by LW and SW
	typedef struct packed {
		logic [`OP_BITS-1:0]  opcode;
		logic [`REG_BITS-1:0] rd;
		logic [`REG_BITS-1:0] rs1;
		logic [3:0]           pad;
		logic signed [15:0]   imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

	// Side that owns the outstanding DRAM read
	typedef enum logic {
		IFETCH,
		DATA
	} mem_owner_e;

endpackage

//--- logic/vx_scheduler.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_scheduler
	import vx_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 instr_valid,
	input  instr_t               instr,
	input  logic                 mem_delay,
	input  logic                 wb_valid,
	input  logic [`REG_BITS-1:0] wb_rd,
	output logic                 schedule_delay,
	output logic                 is_empty
);

	logic [`NUM_REGS-1:0] pending;
	logic [`NUM_REGS-1:0] set_mask;
	logic [`NUM_REGS-1:0] clr_mask;
	logic                 uses_rs2;
	logic                 uses_rd;
	logic                 writes_rd;
	logic                 hazard;

	assign uses_rs2  = (instr.r.opcode == `OP_ADD);
	assign writes_rd = (instr.i.opcode == `OP_ADD) || (instr.i.opcode == `OP_ADDI) ||
		(instr.i.opcode == `OP_LW);
	// SW reads rd as its store data
	assign uses_rd   = writes_rd || (instr.i.opcode == `OP_SW);

	assign hazard = pending[instr.i.rs1] ||
		(uses_rs2 && pending[instr.r.rs2]) ||
		(uses_rd && pending[instr.i.rd]);

	assign schedule_delay = mem_delay || hazard;
	assign is_empty       = !(|pending) && !mem_delay;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (instr_valid && !schedule_delay && writes_rd && instr.i.rd != '0) begin
			set_mask[instr.i.rd] = 1'b1;
		end
		if (wb_valid) begin
			clr_mask[wb_rd] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clr_mask) | set_mask;
		end
	end

endmodule

//--- verif/vx_core_assertions.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_core_assertions (
	input logic             clk,
	input logic             reset,
	input logic             io_valid,
	input logic             dram_req_read,
	input logic             dram_req_write,
	input logic [`XLEN-1:0] dram_req_addr,
	input logic [`XLEN-1:0] dram_req_data,
	input logic             dram_req_ready,
	input logic             out_ebreak
);

	// Held request keeps its strobe and address
	read_held: assert property (@(posedge clk) disable iff (reset)
		dram_req_read && !dram_req_ready |=> dram_req_read && $stable(dram_req_addr))
		else $error("DRAM read request changed while stalled");

	write_held: assert property (@(posedge clk) disable iff (reset)
		dram_req_write && !dram_req_ready |=>
		dram_req_write && $stable(dram_req_addr) && $stable(dram_req_data))
		else $error("DRAM write request changed while stalled");

	io_not_dram: assert property (@(posedge clk) disable iff (reset)
		!(io_valid && dram_req_write))
		else $error("IO store and DRAM write in the same cycle");

	ebreak_sticky: assert property (@(posedge clk) disable iff (reset)
		out_ebreak |=> out_ebreak)
		else $error("out_ebreak dropped after rising");

	// First edge of reset still sees unreset flops
	quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !dram_req_read && !dram_req_write && !io_valid && !out_ebreak)
		else $error("control output high during reset");

endmodule

bind vx_core vx_core_assertions core_checks (
	.clk            (clk),
	.reset          (reset),
	.io_valid       (io_valid),
	.dram_req_read  (dram_req_read),
	.dram_req_write (dram_req_write),
	.dram_req_addr  (dram_req_addr),
	.dram_req_data  (dram_req_data),
	.dram_req_ready (dram_req_ready),
	.out_ebreak     (out_ebreak)
);

//--- verif/vx_core_tb.sv
`timescale 1ns/1ps
`include "vx_defines.svh"

module vx_core_tb;

	localparam int TIMEOUT_CYCLES = 40 * 100;

	logic             clk;
	logic             reset;
	logic             io_valid;
	logic [`XLEN-1:0] io_data;
	logic             dram_req_read;
	logic             dram_req_write;
	logic [`XLEN-1:0] dram_req_addr;
	logic [`XLEN-1:0] dram_req_data;
	logic             dram_req_ready;
	logic             dram_rsp_valid;
	logic [`XLEN-1:0] dram_rsp_data;
	logic             dram_rsp_ready;
	logic             out_ebreak;

	logic [31:0] init_mem [256];
	logic [31:0] dram [256];
	logic [31:0] ref_mem [256];
	logic [31:0] exp_io [$];
	int          exp_tag [$];
	int          errs [1:5];
	int          io_idx;
	int          stall_cycles;
	int          delayed_rsp;
	int          reads_after_ebreak;
	int          cycles;
	int          pass_tests;
	int          fail_tests;
	bit          timed_out;
	bit          rd_pending;
	bit          rsp_taken;
	int          rd_wait;
	logic [7:0]  rd_addr;

	vx_core dut0 (
		.clk            (clk),
		.reset          (reset),
		.io_valid       (io_valid),
		.io_data        (io_data),
		.dram_req_read  (dram_req_read),
		.dram_req_write (dram_req_write),
		.dram_req_addr  (dram_req_addr),
		.dram_req_data  (dram_req_data),
		.dram_req_ready (dram_req_ready),
		.dram_rsp_valid (dram_rsp_valid),
		.dram_rsp_data  (dram_rsp_data),
		.dram_rsp_ready (dram_rsp_ready),
		.out_ebreak     (out_ebreak)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] encode_r(logic [3:0] op, logic [3:0] rd, logic [3:0] rs1,
		logic [3:0] rs2);
		return {op, rd, rs1, rs2, 16'h0000};
	endfunction

	function automatic logic [31:0] encode_i(logic [3:0] op, logic [3:0] rd, logic [3:0] rs1,
		logic [15:0] imm);
		return {op, rd, rs1, 4'h0, imm};
	endfunction

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			init_mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0103);
		end
		init_mem[0]  = encode_i(`OP_ADDI, 4'd1, 4'd0, 16'd5);
		init_mem[1]  = encode_i(`OP_ADDI, 4'd2, 4'd1, 16'd7);
		init_mem[2]  = encode_r(`OP_ADD, 4'd3, 4'd1, 4'd2);
		init_mem[3]  = encode_r(`OP_ADD, 4'd3, 4'd3, 4'd3);
		// Write to r0 must be lost
		init_mem[4]  = encode_i(`OP_ADDI, 4'd0, 4'd3, 16'd9);
		init_mem[5]  = encode_r(`OP_ADD, 4'd10, 4'd0, 4'd2);
		init_mem[6]  = encode_i(`OP_ADDI, 4'd4, 4'd0, 16'hfff0);
		init_mem[7]  = encode_i(`OP_SW, 4'd3, 4'd4, 16'd0);
		init_mem[8]  = encode_i(`OP_SW, 4'd10, 4'd4, 16'd0);
		init_mem[9]  = encode_i(`OP_ADDI, 4'd5, 4'd0, 16'h0200);
		init_mem[10] = encode_i(`OP_SW, 4'd3, 4'd5, 16'd0);
		init_mem[11] = encode_i(`OP_LW, 4'd6, 4'd5, 16'd0);
		init_mem[12] = encode_i(`OP_SW, 4'd6, 4'd4, 16'd0);
		init_mem[13] = encode_i(`OP_LW, 4'd7, 4'd5, 16'd4);
		init_mem[14] = encode_r(`OP_ADD, 4'd8, 4'd7, 4'd6);
		init_mem[15] = encode_i(`OP_SW, 4'd8, 4'd4, 16'd0);
		init_mem[16] = encode_i(`OP_SW, 4'd8, 4'd5, 16'd8);
		init_mem[17] = encode_i(`OP_ADDI, 4'd9, 4'd8, 16'hff9c);
		init_mem[18] = encode_i(`OP_SW, 4'd9, 4'd5, 16'hfffc);
		init_mem[19] = encode_i(`OP_LW, 4'd11, 4'd5, 16'hfffc);
		init_mem[20] = encode_i(`OP_SW, 4'd11, 4'd4, 16'd0);
		init_mem[21] = {`OP_EBREAK, 28'h0};
		dram = init_mem;
	endtask

	// ISA model run straight from the instruction encoding
	function automatic void run_reference();
		logic [31:0] regs [16];
		logic [31:0] word;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		int          pc;
		int          steps;
		bit          loaded;
		bit          done;
		ref_mem = init_mem;
		foreach (regs[i]) regs[i] = '0;
		pc = 0;
		steps = 0;
		loaded = 0;
		done = 0;
		while (!done && steps < 256) begin
			word = ref_mem[(pc >> 2) & 255];
			op   = word[31:28];
			rd   = word[27:24];
			rs1  = word[23:20];
			rs2  = word[19:16];
			imm  = {{16{word[15]}}, word[15:0]};
			addr = regs[rs1] + imm;
			case (op)
				`OP_ADD: if (rd != 0) regs[rd] = regs[rs1] + regs[rs2];
				`OP_ADDI: if (rd != 0) regs[rd] = regs[rs1] + imm;
				`OP_LW: begin
					loaded = 1;
					if (rd != 0) regs[rd] = ref_mem[addr[9:2]];
				end
				`OP_SW: begin
					if (addr == `IO_BUS_ADDR) begin
						exp_io.push_back(regs[rd]);
						exp_tag.push_back(loaded ? 2 : 1);
					end else begin
						ref_mem[addr[9:2]] = regs[rd];
					end
				end
				default: done = 1;
			endcase
			pc += 4;
			steps++;
		end
	endfunction

	// DRAM model, observed mid-cycle and driven after the edge
	initial begin
		dram_req_ready = 1'b0;
		dram_rsp_valid = 1'b0;
		dram_rsp_data  = '0;
		void'($urandom(32'h835c4228));
		forever begin
			@(negedge clk);
			rsp_taken = 0;
			if (!reset) begin
				if ((dram_req_read || dram_req_write) && !dram_req_ready) stall_cycles++;
				if (dram_req_read && out_ebreak) reads_after_ebreak++;
				if (dram_req_write && dram_req_ready) begin
					assert (dram_req_addr != `IO_BUS_ADDR) else begin
						$display("IO store reached the DRAM port at %0t", $time);
						errs[4]++;
					end
					dram[dram_req_addr[9:2]] = dram_req_data;
				end
				if (dram_req_read && dram_req_ready) begin
					rd_addr = dram_req_addr[9:2];
					rd_wait = $urandom_range(3, 0);
					if (rd_wait != 0) delayed_rsp++;
					rd_pending = 1;
				end
				if (dram_rsp_valid && dram_rsp_ready) rsp_taken = 1;
			end
			@(posedge clk);
			#1;
			dram_req_ready = ($urandom_range(3, 0) != 0);
			if (rsp_taken) dram_rsp_valid = 1'b0;
			if (rd_pending) begin
				if (rd_wait == 0) begin
					dram_rsp_valid = 1'b1;
					dram_rsp_data  = dram[rd_addr];
					rd_pending     = 0;
				end else begin
					rd_wait--;
				end
			end
		end
	end

	// IO checker
	always @(negedge clk) begin
		if (!reset && io_valid) begin
			assert (io_idx < exp_io.size()) else begin
				$display("unexpected IO write at %0t beyond the %0d expected", $time,
					exp_io.size());
				errs[5]++;
			end
			if (io_idx < exp_io.size()) begin
				assert (io_data == exp_io[io_idx]) else begin
					$display("mismatch at %0t: io_data expected %h got %h", $time,
						exp_io[io_idx], io_data);
					errs[exp_tag[io_idx]]++;
				end
			end
			io_idx++;
		end
	end

	task automatic report_test(input int id, input string name);
		if (errs[id] == 0) begin
			pass_tests++;
			$display("test %0d %s: PASS", id, name);
		end else begin
			fail_tests++;
			$display("test %0d %s: FAIL with %0d errors", id, name, errs[id]);
		end
	endtask

	initial begin
		reset = 1'b1;
		load_program();
		run_reference();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		cycles = 0;
		while (!out_ebreak && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		timed_out = !out_ebreak;
		if (timed_out) begin
			$display("timeout: ebreak never reached");
			errs[5]++;
		end
		// Window to catch stray fetches after the halt
		repeat (20) @(posedge clk);
		#1;
		foreach (ref_mem[i]) begin
			assert (dram[i] == ref_mem[i]) else begin
				$display("mismatch at %0t: dram[%0d] expected %h got %h", $time, i,
					ref_mem[i], dram[i]);
				errs[4]++;
			end
		end
		assert (errs[1] + errs[2] == 0 && io_idx == exp_io.size()) else begin
			$display("IO sequence differs under random DRAM timing");
			errs[3]++;
		end
		assert (stall_cycles > 0 && delayed_rsp > 0) else begin
			$display("random DRAM back-pressure or delay never occurred");
			errs[3]++;
		end
		assert (io_idx == exp_io.size()) else begin
			$display("IO count is %0d, expected %0d", io_idx, exp_io.size());
			errs[5]++;
		end
		assert (reads_after_ebreak == 0) else begin
			$display("%0d DRAM reads after ebreak", reads_after_ebreak);
			errs[5]++;
		end
		report_test(1, "alu chains");
		report_test(2, "load after store");
		report_test(3, "random dram timing");
		report_test(4, "io stores kept off dram");
		report_test(5, "ebreak halt");
		$display("%0d tests passed, %0d failed", pass_tests, fail_tests);
		if (fail_tests == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
